/* bench/tb_clk_gen.sv */
// Clock and reset source for the testbench.
// Reset is held low for rst_cycles rising edges, then released
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int period_ns  = 8,
  parameter int rst_cycles = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (rst_cycles) @(posedge clk_o);
    #1 rst_no = 1'b1;  // Released away from the edge
  end

endmodule

/* bench/tb_top.sv */
// Testbench for the peripheral subsystem. Acts as the bus host, keeps
// register models and checks the DUT against them with assertions
`timescale 1ns/100ps

module tb_top import bus_pkg::*, periph_pkg::*; ();

  localparam int clk_period_ns = 8;
  localparam int rst_cycles    = 8;
  localparam int run_cycles    = 40 + 20 + 140 + 300 + 200;  // GPIO, bus, timer, PWM, margin

  logic                  clk_sys_i, rst_sys_ni;
  logic                  host_req_i, host_we_i, host_rvalid_o, host_err_o, timer_irq_o;
  bus_be_t               host_be_i;
  bus_addr_t             host_addr_i, win, off;
  bus_data_t             host_wdata_i, host_rdata_o, exp_rdata_d, rsp_rdata_q;
  logic [gpi_w-1:0]      gp_i;
  logic [gpo_w-1:0]      gp_o, gpo_model;
  logic [pwm_chan_n-1:0] pwm_o, pwm_exp;
  logic                  rsp_vld_q, rsp_err_q;
  logic [pwm_ctr_w-1:0]  ctr_model;
  logic [pwm_ctr_w-1:0]  duty_model [pwm_chan_n];
  logic [tmr_w-1:0]      mtime_model, mtime_nxt, cmp_model;
  logic [31:0]           lcg_state = 32'd9;

  tb_clk_gen #(.period_ns(clk_period_ns), .rst_cycles(rst_cycles)) u_clk_gen (
    .clk_o  (clk_sys_i),
    .rst_no (rst_sys_ni)
  );

  demo_periph_top dut (.*);

  // Low state bits repeat quickly, so the upper half is returned in the low bits
  function automatic bus_data_t next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  function automatic bus_data_t strobe_bytes(bus_data_t old_v, bus_data_t new_v, bus_be_t be);
    for (int b = 0; b < bus_be_w; b++) begin
      if (be[b]) old_v[8*b +: 8] = new_v[8*b +: 8];
    end
    return old_v;
  endfunction

  function automatic logic mapped(bus_addr_t a);
    bus_addr_t w;
    w = a & periph_win_mask;
    return (w == gpio_base) || (w == pwm_base) || (w == timer_base);
  endfunction

  task automatic fail_run(string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic value_error(string sig, logic [63:0] exp, logic [63:0] act);
    fail_run($sformatf("[ERROR] %s expected 0x%0h actual 0x%0h", sig, exp, act));
  endtask

  task automatic idle_cycles(int n);
    repeat (n) @(posedge clk_sys_i);
    #1;
  endtask

  // One request for one cycle, exp is the read data it must return
  task automatic bus_issue(logic we, bus_be_t be, bus_addr_t addr, bus_data_t wdata,
                           bus_data_t exp);
    host_req_i   = 1'b1;
    host_we_i    = we;
    host_be_i    = be;
    host_addr_i  = addr;
    host_wdata_i = wdata;
    exp_rdata_d  = exp;
    idle_cycles(1);
    host_req_i   = 1'b0;
  endtask

  task automatic bus_read(bus_addr_t addr, bus_data_t exp, output bus_data_t rd);
    bus_issue(1'b0, 4'hF, addr, '0, exp);
    if (!host_rvalid_o) fail_run("No response in the cycle after a read request");
    rd = host_rdata_o;
  endtask

  assign win       = host_addr_i & periph_win_mask;
  assign off       = host_addr_i & ~periph_win_mask;
  assign mtime_nxt = mtime_model + 1'b1;

  // Register models, updated on the edge that accepts a write
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rsp_vld_q   <= 1'b0;
      rsp_err_q   <= 1'b0;
      rsp_rdata_q <= '0;
      gpo_model   <= '0;
      ctr_model   <= '0;
      mtime_model <= '0;
      cmp_model   <= '1;
      for (int n = 0; n < pwm_chan_n; n++) duty_model[n] <= '0;
    end else begin
      rsp_vld_q   <= host_req_i;
      rsp_err_q   <= host_req_i && !mapped(host_addr_i);
      rsp_rdata_q <= (host_we_i || !mapped(host_addr_i)) ? '0 : exp_rdata_d;
      ctr_model   <= ctr_model + 1'b1;
      mtime_model <= mtime_nxt;
      if (host_req_i && host_we_i) begin
        case (win)
          gpio_base: if (off == gpio_out_off)
            gpo_model <= gpo_w'(strobe_bytes(bus_data_t'(gpo_model), host_wdata_i, host_be_i));
          pwm_base: if (off < bus_addr_t'(4 * pwm_chan_n) && host_be_i[0])
            duty_model[off[5:2]] <= host_wdata_i[pwm_ctr_w-1:0];
          timer_base: case (off)
            tmr_time_lo_off: mtime_model[31:0] <=
                strobe_bytes(mtime_nxt[31:0], host_wdata_i, host_be_i);
            tmr_time_hi_off: mtime_model[63:32] <=
                strobe_bytes(mtime_nxt[63:32], host_wdata_i, host_be_i);
            tmr_cmp_lo_off: cmp_model[31:0] <=
                strobe_bytes(cmp_model[31:0], host_wdata_i, host_be_i);
            tmr_cmp_hi_off: cmp_model[63:32] <=
                strobe_bytes(cmp_model[63:32], host_wdata_i, host_be_i);
            default: ;
          endcase
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    for (int n = 0; n < pwm_chan_n; n++) pwm_exp[n] = ctr_model < duty_model[n];
  end

  a_rvalid: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    host_rvalid_o == rsp_vld_q)
    else value_error("host_rvalid_o", 64'($sampled(rsp_vld_q)), 64'($sampled(host_rvalid_o)));
  a_err: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    host_err_o == rsp_err_q)
    else value_error("host_err_o", 64'($sampled(rsp_err_q)), 64'($sampled(host_err_o)));
  a_rdata: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    !rsp_vld_q || (host_rdata_o == rsp_rdata_q))
    else value_error("host_rdata_o", 64'($sampled(rsp_rdata_q)), 64'($sampled(host_rdata_o)));
  a_gpo: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    gp_o == gpo_model)
    else value_error("gp_o", 64'($sampled(gpo_model)), 64'($sampled(gp_o)));
  a_irq: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    timer_irq_o == (mtime_model >= cmp_model))
    else value_error("timer_irq_o", 64'($sampled(mtime_model >= cmp_model)),
                     64'($sampled(timer_irq_o)));
  a_pwm: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    pwm_o == pwm_exp)
    else value_error("pwm_o", 64'($sampled(pwm_exp)), 64'($sampled(pwm_o)));

  initial begin
    #(run_cycles * clk_period_ns);
    fail_run("Timeout: the tests did not finish in the expected time");
  end

  initial begin
    bus_data_t rd;
    bus_data_t wv;
    int        cnt;
    int        high_cnt [pwm_chan_n];
    host_req_i   = 1'b0;
    host_we_i    = 1'b0;
    host_be_i    = '0;
    host_addr_i  = '0;
    host_wdata_i = '0;
    exp_rdata_d  = '0;
    gp_i         = '0;
    wait (rst_sys_ni);
    idle_cycles(1);

    for (int i = 0; i < 16; i++) begin  // GPIO output under random strobes
      bus_issue(1'b1, bus_be_t'(next_rand()), gpio_base + gpio_out_off, next_rand(), '0);
    end
    bus_issue(1'b0, 4'hF, gpio_base + gpio_out_off, '0, bus_data_t'(gpo_model));
    rd = next_rand();
    gp_i = rd[gpi_w-1:0];
    idle_cycles(3);  // Through the synchronizer
    bus_issue(1'b0, 4'hF, gpio_base + gpio_in_off, '0, bus_data_t'(gp_i));

    // Back-to-back mix with unmapped addresses
    bus_issue(1'b0, 4'hF, pwm_base, '0, bus_data_t'(duty_model[0]));
    bus_issue(1'b0, 4'hF, 32'h8000_1000, '0, '0);
    bus_issue(1'b1, 4'hF, 32'h4000_0000, next_rand(), '0);
    bus_issue(1'b0, 4'hF, timer_base + tmr_time_lo_off, '0, mtime_model[31:0]);
    bus_issue(1'b0, 4'hF, timer_base + tmr_cmp_hi_off, '0, cmp_model[63:32]);
    bus_issue(1'b1, 4'h3, gpio_base + gpio_out_off, next_rand(), '0);
    bus_issue(1'b0, 4'hF, gpio_base + 32'h8, '0, '0);
    idle_cycles(1);

    bus_read(timer_base + tmr_time_lo_off, mtime_model[31:0], rd);
    bus_issue(1'b1, 4'hF, timer_base + tmr_cmp_lo_off, rd + 32'd64, '0);
    bus_issue(1'b1, 4'hF, timer_base + tmr_cmp_hi_off, '0, '0);
    if (timer_irq_o) fail_run("Timer interrupt high before mtime reached mtimecmp");
    cnt = 0;
    while (!timer_irq_o && cnt < 80) begin
      idle_cycles(1);
      cnt++;
    end
    if (!timer_irq_o) fail_run("Timer interrupt did not rise within 80 cycles");
    idle_cycles(20);
    bus_issue(1'b1, 4'hF, timer_base + tmr_cmp_lo_off, '1, '0);
    bus_issue(1'b1, 4'hF, timer_base + tmr_cmp_hi_off, '1, '0);
    idle_cycles(2);
    if (timer_irq_o) fail_run("Timer interrupt still high with mtimecmp at all ones");

    wv = next_rand() & 32'h0FFF_FFFF;
    bus_issue(1'b1, 4'hF, timer_base + tmr_time_lo_off, wv, '0);
    idle_cycles(3);
    bus_read(timer_base + tmr_time_lo_off, mtime_model[31:0], rd);
    assert ((rd - wv >= 32'd1) && (rd - wv <= 32'd8))
      else fail_run($sformatf("[ERROR] host_rdata_o 0x%0h not 1 to 8 cycles past mtime 0x%0h",
                              rd, wv));

    for (int n = 0; n < pwm_chan_n; n++) begin
      wv = (n == 3) ? '0 : next_rand();  // Channel 3 stays off
      bus_issue(1'b1, 4'h1, pwm_base + bus_addr_t'(4 * n), wv, '0);
    end
    bus_issue(1'b0, 4'hF, pwm_base + 32'h8, '0, bus_data_t'(duty_model[2]));
    bus_issue(1'b0, 4'hF, pwm_base + 32'h40, '0, '0);
    for (int n = 0; n < pwm_chan_n; n++) high_cnt[n] = 0;
    for (int c = 0; c < 256; c++) begin  // One full counter period
      idle_cycles(1);
      for (int n = 0; n < pwm_chan_n; n++) high_cnt[n] += int'(pwm_o[n]);
    end
    for (int n = 0; n < pwm_chan_n; n++) begin
      assert (high_cnt[n] == int'(duty_model[n]))
        else value_error($sformatf("pwm_o[%0d] high cycles", n), 64'(duty_model[n]),
                         64'(high_cnt[n]));
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

/* hdl/bus_decoder.sv */
// Address decoder between the single bus host and the three devices.
// Requests fan out in the same cycle, responses come back one cycle later
`timescale 1ns/100ps

module bus_decoder import bus_pkg::*, periph_pkg::*; (
  input  logic      clk_sys_i,
  input  logic      rst_sys_ni,

  input  logic      host_req_i,
  input  logic      host_we_i,
  input  bus_be_t   host_be_i,
  input  bus_addr_t host_addr_i,
  input  bus_data_t host_wdata_i,
  output logic      host_rvalid_o,
  output bus_data_t host_rdata_o,
  output logic      host_err_o,

  dev_bus_if.dec    gpio_bus_o,
  dev_bus_if.dec    pwm_bus_o,
  dev_bus_if.dec    timer_bus_o
);

  dev_sel_e  sel_d, sel_q;
  logic      err_q;
  bus_addr_t win_addr;
  bus_addr_t offset;

  assign win_addr = host_addr_i & periph_win_mask;
  assign offset   = host_addr_i & ~periph_win_mask;

  always_comb begin
    if (win_addr == gpio_base)       sel_d = dev_gpio;
    else if (win_addr == pwm_base)   sel_d = dev_pwm;
    else if (win_addr == timer_base) sel_d = dev_timer;
    else                             sel_d = dev_none;
  end

  // Only the selected device sees req, the rest goes to all
  assign gpio_bus_o.req  = host_req_i && (sel_d == dev_gpio);
  assign pwm_bus_o.req   = host_req_i && (sel_d == dev_pwm);
  assign timer_bus_o.req = host_req_i && (sel_d == dev_timer);

  assign gpio_bus_o.we     = host_we_i;
  assign gpio_bus_o.be     = host_be_i;
  assign gpio_bus_o.addr   = offset;
  assign gpio_bus_o.wdata  = host_wdata_i;
  assign pwm_bus_o.we      = host_we_i;
  assign pwm_bus_o.be      = host_be_i;
  assign pwm_bus_o.addr    = offset;
  assign pwm_bus_o.wdata   = host_wdata_i;
  assign timer_bus_o.we    = host_we_i;
  assign timer_bus_o.be    = host_be_i;
  assign timer_bus_o.addr  = offset;
  assign timer_bus_o.wdata = host_wdata_i;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      sel_q <= dev_none;
      err_q <= 1'b0;
    end else begin
      sel_q <= host_req_i ? sel_d : dev_none;
      err_q <= host_req_i && (sel_d == dev_none);  // Unmapped address
    end
  end

  always_comb begin
    case (sel_q)
      dev_gpio: begin
        host_rvalid_o = gpio_bus_o.rvalid;
        host_rdata_o  = gpio_bus_o.rdata;
      end
      dev_pwm: begin
        host_rvalid_o = pwm_bus_o.rvalid;
        host_rdata_o  = pwm_bus_o.rdata;
      end
      dev_timer: begin
        host_rvalid_o = timer_bus_o.rvalid;
        host_rdata_o  = timer_bus_o.rdata;
      end
      default: begin
        host_rvalid_o = err_q;  // Error response carries no data
        host_rdata_o  = '0;
      end
    endcase
  end
  assign host_err_o = err_q;

  a_single_dev_req: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    $onehot0({gpio_bus_o.req, pwm_bus_o.req, timer_bus_o.req}));

  // Devices must answer in exactly one cycle for this to hold
  a_rsp_one_cycle: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    host_rvalid_o == $past(host_req_i));

endmodule

/* hdl/bus_pkg.sv */
// Bus widths and strobe types shared by the host decoder, the device
// interface and every register block
package bus_pkg;

  localparam int bus_addr_w = 32;
  localparam int bus_data_w = 32;
  localparam int bus_be_w   = bus_data_w / 8;  // One strobe per byte lane

  typedef logic [bus_addr_w-1:0] bus_addr_t;
  typedef logic [bus_data_w-1:0] bus_data_t;
  typedef logic [bus_be_w-1:0]   bus_be_t;

  // Replaces the byte lanes of old_v whose strobe is set
  function automatic bus_data_t be_merge(bus_data_t old_v, bus_data_t new_v, bus_be_t be);
    bus_data_t res;
    res = old_v;
    for (int b = 0; b < bus_be_w; b++) begin
      if (be[b]) res[8*b +: 8] = new_v[8*b +: 8];
    end
    return res;
  endfunction

endpackage

/* hdl/demo_periph_top.sv */
// Peripheral subsystem top level. The bus host drives the plain host
// ports, the decoder routes each request to GPIO, PWM or timer
`timescale 1ns/100ps

module demo_periph_top import bus_pkg::*, periph_pkg::*; (
  input  logic                  clk_sys_i,
  input  logic                  rst_sys_ni,

  input  logic                  host_req_i,
  input  logic                  host_we_i,
  input  bus_be_t               host_be_i,
  input  bus_addr_t             host_addr_i,
  input  bus_data_t             host_wdata_i,
  output logic                  host_rvalid_o,
  output bus_data_t             host_rdata_o,
  output logic                  host_err_o,

  input  logic [gpi_w-1:0]      gp_i,
  output logic [gpo_w-1:0]      gp_o,
  output logic [pwm_chan_n-1:0] pwm_o,
  output logic                  timer_irq_o
);

  dev_bus_if gpio_bus ();
  dev_bus_if pwm_bus ();
  dev_bus_if timer_bus ();

  bus_decoder u_bus_decoder (
    .clk_sys_i     (clk_sys_i),
    .rst_sys_ni    (rst_sys_ni),
    .host_req_i    (host_req_i),
    .host_we_i     (host_we_i),
    .host_be_i     (host_be_i),
    .host_addr_i   (host_addr_i),
    .host_wdata_i  (host_wdata_i),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .host_err_o    (host_err_o),
    .gpio_bus_o    (gpio_bus),
    .pwm_bus_o     (pwm_bus),
    .timer_bus_o   (timer_bus)
  );

  gpio_regs u_gpio_regs (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .bus_i      (gpio_bus),
    .gp_i       (gp_i),
    .gp_o       (gp_o)
  );

  pwm_bank u_pwm_bank (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .bus_i      (pwm_bus),
    .pwm_o      (pwm_o)
  );

  timer_regs u_timer_regs (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_ni),
    .bus_i       (timer_bus),
    .timer_irq_o (timer_irq_o)
  );

endmodule

/* hdl/dev_bus_if.sv */
// One decoded request towards a device and its response back.
// The decoder holds the dec side, each device the dev side
`timescale 1ns/100ps

interface dev_bus_if import bus_pkg::*; ();

  logic      req;
  logic      we;
  bus_be_t   be;
  bus_addr_t addr;    // Offset inside the device window
  bus_data_t wdata;

  logic      rvalid;  // One cycle after req
  bus_data_t rdata;   // Zero for writes

  modport dec (
    output req,
    output we,
    output be,
    output addr,
    output wdata,
    input  rvalid,
    input  rdata
  );

  modport dev (
    input  req,
    input  we,
    input  be,
    input  addr,
    input  wdata,
    output rvalid,
    output rdata
  );

endinterface

/* hdl/gpio_regs.sv */
// GPIO register block with a byte-writable output register and a
// synchronized input register
`timescale 1ns/100ps

module gpio_regs import bus_pkg::*, periph_pkg::*; (
  input  logic             clk_sys_i,
  input  logic             rst_sys_ni,

  dev_bus_if.dev           bus_i,

  input  logic [gpi_w-1:0] gp_i,
  output logic [gpo_w-1:0] gp_o
);

  logic [gpo_w-1:0] gpo_q;
  logic [gpi_w-1:0] gpi_meta_q;
  logic [gpi_w-1:0] gpi_sync_q;
  bus_data_t        rdata_d;

  always_comb begin
    case (bus_i.addr)
      gpio_out_off: rdata_d = bus_data_t'(gpo_q);
      gpio_in_off:  rdata_d = bus_data_t'(gpi_sync_q);
      default:      rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpo_q        <= '0;
      gpi_meta_q   <= '0;
      gpi_sync_q   <= '0;
      bus_i.rvalid <= 1'b0;
      bus_i.rdata  <= '0;
    end else begin
      gpi_meta_q <= gp_i;        // Two flop synchronizer
      gpi_sync_q <= gpi_meta_q;
      if (bus_i.req && bus_i.we && (bus_i.addr == gpio_out_off)) begin
        gpo_q <= gpo_w'(be_merge(bus_data_t'(gpo_q), bus_i.wdata, bus_i.be));
      end
      bus_i.rvalid <= bus_i.req;
      bus_i.rdata  <= (bus_i.req && !bus_i.we) ? rdata_d : '0;
    end
  end

  assign gp_o = gpo_q;

endmodule

/* hdl/periph_pkg.sv */
// Memory map and register layout of the peripheral subsystem.
// Used by the decoder, the three devices and the testbench models
package periph_pkg;

  import bus_pkg::*;

  // Target of one host request
  typedef enum logic [1:0] {
    dev_gpio,
    dev_pwm,
    dev_timer,
    dev_none
  } dev_sel_e;

  // 4 KiB windows
  localparam bus_addr_t periph_win_mask = 32'hFFFF_F000;
  localparam bus_addr_t gpio_base       = 32'h8000_0000;
  localparam bus_addr_t timer_base      = 32'h8000_2000;
  localparam bus_addr_t pwm_base        = 32'h8000_3000;

  // GPIO registers
  localparam bus_addr_t gpio_out_off = 32'h0;
  localparam bus_addr_t gpio_in_off  = 32'h4;
  localparam int gpi_w = 8;
  localparam int gpo_w = 16;

  // Machine timer, 64 bits split into two words
  localparam bus_addr_t tmr_time_lo_off = 32'h0;
  localparam bus_addr_t tmr_time_hi_off = 32'h4;
  localparam bus_addr_t tmr_cmp_lo_off  = 32'h8;
  localparam bus_addr_t tmr_cmp_hi_off  = 32'hC;
  localparam int tmr_w = 64;

  // PWM bank, duty of channel n at offset 4*n
  localparam int pwm_chan_n = 12;
  localparam int pwm_ctr_w  = 8;
  localparam int pwm_idx_w  = $clog2(pwm_chan_n);

endpackage

/* hdl/pwm_bank.sv */
// Bank of PWM channels sharing one free-running counter.
// A channel is high while the counter is below its duty value
`timescale 1ns/100ps

module pwm_bank import bus_pkg::*, periph_pkg::*; (
  input  logic                  clk_sys_i,
  input  logic                  rst_sys_ni,

  dev_bus_if.dev                bus_i,

  output logic [pwm_chan_n-1:0] pwm_o
);

  logic [pwm_ctr_w-1:0] ctr_q;
  logic [pwm_ctr_w-1:0] duty_q [pwm_chan_n];
  logic [pwm_idx_w-1:0] chan_idx;
  logic                 chan_hit;
  bus_data_t            rdata_d;

  // Word offset selects the channel
  assign chan_idx = bus_i.addr[2 +: pwm_idx_w];
  assign chan_hit = bus_i.addr < bus_addr_t'(4 * pwm_chan_n);

  assign rdata_d = chan_hit ? bus_data_t'(duty_q[chan_idx]) : '0;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      ctr_q <= '0;
      for (int n = 0; n < pwm_chan_n; n++) begin
        duty_q[n] <= '0;
      end
      bus_i.rvalid <= 1'b0;
      bus_i.rdata  <= '0;
    end else begin
      ctr_q <= ctr_q + 1'b1;  // Wraps every 256 cycles
      if (bus_i.req && bus_i.we && chan_hit && bus_i.be[0]) begin
        duty_q[chan_idx] <= bus_i.wdata[pwm_ctr_w-1:0];
      end
      bus_i.rvalid <= bus_i.req;
      bus_i.rdata  <= (bus_i.req && !bus_i.we) ? rdata_d : '0;
    end
  end

  // Duty 0 keeps the channel low, duty 255 leaves one low cycle per period
  always_comb begin
    for (int n = 0; n < pwm_chan_n; n++) begin
      pwm_o[n] = ctr_q < duty_q[n];
    end
  end

endmodule

/* hdl/timer_regs.sv */
// Machine timer with 64-bit mtime and mtimecmp registers.
// Raises a level interrupt while mtime is at or above mtimecmp
`timescale 1ns/100ps

module timer_regs import bus_pkg::*, periph_pkg::*; (
  input  logic   clk_sys_i,
  input  logic   rst_sys_ni,

  dev_bus_if.dev bus_i,

  output logic   timer_irq_o
);

  logic [tmr_w-1:0] mtime_q;
  logic [tmr_w-1:0] mtimecmp_q;
  logic [tmr_w-1:0] mtime_inc;
  logic             wr;
  bus_data_t        rdata_d;

  assign wr        = bus_i.req && bus_i.we;
  assign mtime_inc = mtime_q + 1'b1;

  always_comb begin
    case (bus_i.addr)
      tmr_time_lo_off: rdata_d = mtime_q[bus_data_w-1:0];
      tmr_time_hi_off: rdata_d = mtime_q[tmr_w-1:bus_data_w];
      tmr_cmp_lo_off:  rdata_d = mtimecmp_q[bus_data_w-1:0];
      tmr_cmp_hi_off:  rdata_d = mtimecmp_q[tmr_w-1:bus_data_w];
      default:         rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q      <= '0;
      mtimecmp_q   <= '1;  // No interrupt until software sets a compare value
      bus_i.rvalid <= 1'b0;
      bus_i.rdata  <= '0;
    end else begin
      mtime_q <= mtime_inc;
      if (wr) begin
        // A written half replaces the incremented value in the strobed bytes
        case (bus_i.addr)
          tmr_time_lo_off: mtime_q[bus_data_w-1:0] <=
              be_merge(mtime_inc[bus_data_w-1:0], bus_i.wdata, bus_i.be);
          tmr_time_hi_off: mtime_q[tmr_w-1:bus_data_w] <=
              be_merge(mtime_inc[tmr_w-1:bus_data_w], bus_i.wdata, bus_i.be);
          tmr_cmp_lo_off: mtimecmp_q[bus_data_w-1:0] <=
              be_merge(mtimecmp_q[bus_data_w-1:0], bus_i.wdata, bus_i.be);
          tmr_cmp_hi_off: mtimecmp_q[tmr_w-1:bus_data_w] <=
              be_merge(mtimecmp_q[tmr_w-1:bus_data_w], bus_i.wdata, bus_i.be);
          default: ;
        endcase
      end
      bus_i.rvalid <= bus_i.req;
      bus_i.rdata  <= (bus_i.req && !bus_i.we) ? rdata_d : '0;
    end
  end

  assign timer_irq_o = mtime_q >= mtimecmp_q;

  // Reset values of mtime and mtimecmp must keep the line quiet
  a_irq_low_after_reset: assert property (@(posedge clk_sys_i)
    $rose(rst_sys_ni) |-> !timer_irq_o);

endmodule

/* project.f */
hdl/bus_pkg.sv
hdl/periph_pkg.sv
hdl/dev_bus_if.sv
hdl/bus_decoder.sv
hdl/gpio_regs.sv
hdl/pwm_bank.sv
hdl/timer_regs.sv
hdl/demo_periph_top.sv
bench/tb_clk_gen.sv
bench/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_top -f project.f -o tb_top_sim
./obj_dir/tb_top_sim 2>&1 | tee sim.log
if grep -q "TB FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
